//--- rtl/armPkg.sv
// ARMv4 subset encodings only; imm8 rotate bits are ignored, op 11 and cond 1111 never execute
package armPkg;

   // Major opcode, Instr[27:26]
   localparam logic [1:0] OpData   = 2'b00;
   localparam logic [1:0] OpMem    = 2'b01;
   localparam logic [1:0] OpBranch = 2'b10;

   // Data processing cmd field
   localparam logic [3:0] CmdAnd = 4'b0000;
   localparam logic [3:0] CmdSub = 4'b0010;
   localparam logic [3:0] CmdAdd = 4'b0100;
   localparam logic [3:0] CmdOrr = 4'b1100;

   // Condition field codes
   localparam logic [3:0] CondEq = 4'b0000;
   localparam logic [3:0] CondNe = 4'b0001;
   localparam logic [3:0] CondCs = 4'b0010;
   localparam logic [3:0] CondCc = 4'b0011;
   localparam logic [3:0] CondMi = 4'b0100;
   localparam logic [3:0] CondPl = 4'b0101;
   localparam logic [3:0] CondVs = 4'b0110;
   localparam logic [3:0] CondVc = 4'b0111;
   localparam logic [3:0] CondHi = 4'b1000;
   localparam logic [3:0] CondLs = 4'b1001;
   localparam logic [3:0] CondGe = 4'b1010;
   localparam logic [3:0] CondLt = 4'b1011;
   localparam logic [3:0] CondGt = 4'b1100;
   localparam logic [3:0] CondLe = 4'b1101;
   localparam logic [3:0] CondAl = 4'b1110;
   // Never executes in this core
   localparam logic [3:0] CondNv = 4'b1111;

   // PC step and R15 read offset
   localparam logic [31:0] WordBytes    = 32'd4;
   localparam logic [31:0] PcReadOffset = 32'd8;

   // ADD, SUB, AND, ORR
   typedef enum logic [1:0] {AluAdd, AluSub, AluAnd, AluOrr} aluOp;

   // Immediate extension kind
   typedef enum logic [1:0] {ImmDp8, ImmMem12, ImmBranch} immKind;

   // Data processing layout
   typedef struct packed {
      logic [3:0] cond;
      logic [1:0] op;
      logic       immFlag;
      logic [3:0] cmd;
      logic       sBit;
      logic [3:0] rn;
      logic [3:0] rd;
      // Rotate field, unused here
      logic [3:0] rot;
      // imm8, or {0000, rm} for register form
      logic [7:0] src2;
   } dpFields;

   // LDR / STR layout
   typedef struct packed {
      logic [3:0]  cond;
      logic [1:0]  op;
      logic [4:0]  funct;
      logic        lBit;
      logic [3:0]  rn;
      logic [3:0]  rd;
      logic [11:0] imm12;
   } memFields;

   // B layout
   typedef struct packed {
      logic [3:0]  cond;
      logic [1:0]  op;
      logic [1:0]  funct;
      logic [23:0] imm24;
   } brFields;

   // One instruction word, three decodings
   typedef union packed {
      dpFields  dpView;
      memFields memView;
      brFields  brView;
   } instrWord;

   // Decoder output, before condition gating
   typedef struct packed {
      // [0] ra1 = 15, [1] ra2 = rd
      logic [1:0] regSrc;
      immKind     immSel;
      logic       aluSrc;
      logic       memToReg;
      logic       regW;
      logic       memW;
      logic       branch;
      // [1] N/Z, [0] C/V
      logic [1:0] flagW;
      aluOp       aluCtl;
      logic       memStrobe;
   } ctrlWord;

   typedef struct packed {
      logic n;
      logic z;
      logic c;
      logic v;
   } aluFlags;

endpackage

//--- rtl/alu.sv
// Combinational 32-bit ALU; C and V are zero for AND and ORR
module alu (
   input  logic [31:0]     a,
   input  logic [31:0]     b,
   input  armPkg::aluOp    ctl,
   output logic [31:0]     result,
   output armPkg::aluFlags flags
);

   logic        isSub;
   logic        isArith;
   logic [31:0] bIn;
   logic [32:0] sum;

   assign isSub   = (ctl == armPkg::AluSub);
   assign isArith = (ctl == armPkg::AluAdd) || isSub;

   // Subtract as a + ~b + 1
   assign bIn = isSub ? ~b : b;
   assign sum = {1'b0, a} + {1'b0, bIn} + {32'd0, isSub};

   always_comb
   begin
      case (ctl)
         armPkg::AluAnd: result = a & b;
         armPkg::AluOrr: result = a | b;
         // ADD and SUB share the adder
         default:        result = sum[31:0];
      endcase
   end

   assign flags.n = result[31];
   assign flags.z = (result == 32'd0);
   // Carry out, so no borrow on SUB
   assign flags.c = isArith & sum[32];
   // Same operand signs, result sign flipped
   assign flags.v = isArith & (a[31] == bIn[31]) & (sum[31] != a[31]);

endmodule

//--- rtl/regFile.sv
// Register contents are undefined after reset; writes to R15 are dropped
module regFile (
   input  logic        clk,
   input  logic        we,
   input  logic [3:0]  ra1,
   input  logic [3:0]  ra2,
   input  logic [3:0]  wa,
   input  logic [31:0] wd,
   input  logic [31:0] r15,
   output logic [31:0] rd1,
   output logic [31:0] rd2
);

   // R0..R14 only
   logic [31:0] regs [15];
   logic        wrLow;

   // R15 is the PC, never stored here
   assign wrLow = we && (wa != 4'd15);

   always_ff @(posedge clk)
   begin
      if (wrLow)
      begin
         regs[wa] <= wd;
      end
   end

   // Two async read ports, R15 reads PC+8
   assign rd1 = (ra1 == 4'd15) ? r15 : regs[ra1];
   assign rd2 = (ra2 == 4'd15) ? r15 : regs[ra2];

endmodule

//--- rtl/armDecoder.sv
// Purely combinational; op 11 decodes as a no-op and the B link bit is ignored
module armDecoder (
   input  armPkg::instrWord instr,
   output armPkg::ctrlWord  ctrl
);

   armPkg::aluOp aluSel;
   logic [1:0]   flagSel;
   logic         isArith;

   // ALU decoder, data processing cmd field
   always_comb
   begin
      case (instr.dpView.cmd)
         armPkg::CmdAdd: aluSel = armPkg::AluAdd;
         armPkg::CmdSub: aluSel = armPkg::AluSub;
         armPkg::CmdAnd: aluSel = armPkg::AluAnd;
         armPkg::CmdOrr: aluSel = armPkg::AluOrr;
         // Anything else runs as ADD
         default:        aluSel = armPkg::AluAdd;
      endcase
   end

   assign isArith = (aluSel == armPkg::AluAdd) || (aluSel == armPkg::AluSub);

   // S bit writes N/Z, C/V only on arithmetic
   assign flagSel = {instr.dpView.sBit, instr.dpView.sBit & isArith};

   // Main decoder
   always_comb
   begin
      // Default is no write of any kind
      ctrl        = '0;
      ctrl.immSel = armPkg::ImmDp8;
      ctrl.aluCtl = armPkg::AluAdd;
      case (instr.dpView.op)
         armPkg::OpData:
         begin
            ctrl.aluSrc = instr.dpView.immFlag;
            ctrl.regW   = 1'b1;
            ctrl.flagW  = flagSel;
            ctrl.aluCtl = aluSel;
         end
         armPkg::OpMem:
         begin
            // Address is rn + imm12
            ctrl.immSel    = armPkg::ImmMem12;
            ctrl.aluSrc    = 1'b1;
            ctrl.memStrobe = 1'b1;
            if (instr.memView.lBit)
            begin
               // LDR writes read data back to rd
               ctrl.memToReg = 1'b1;
               ctrl.regW     = 1'b1;
            end
            else
            begin
               // STR sends rd out on port 2
               ctrl.regSrc[1] = 1'b1;
               ctrl.memW      = 1'b1;
            end
         end
         armPkg::OpBranch:
         begin
            // Target from R15 (PC+8) plus shifted offset
            ctrl.regSrc[0] = 1'b1;
            ctrl.immSel    = armPkg::ImmBranch;
            ctrl.aluSrc    = 1'b1;
            ctrl.branch    = 1'b1;
         end
         default:
         begin
            ctrl.regW = 1'b0;
         end
      endcase
   end

endmodule

//--- rtl/condUnit.sv
// Flags clear on reset; cond 1111 never executes and PCReady low suppresses every write
module condUnit (
   input  logic             clk,
   input  logic             reset,
   input  armPkg::instrWord instr,
   input  armPkg::ctrlWord  ctrl,
   input  armPkg::aluFlags  flagsIn,
   input  logic             PCReady,
   output logic             regWrite,
   output logic             pcBranch,
   output logic             memWrite,
   output logic             memStrobe
);

   armPkg::aluFlags flags;
   logic            condEx;
   logic            execOk;
   logic [1:0]      flagWrite;

   // Condition check against stored flags
   always_comb
   begin
      case (instr.dpView.cond)
         armPkg::CondEq: condEx = flags.z;
         armPkg::CondNe: condEx = ~flags.z;
         armPkg::CondCs: condEx = flags.c;
         armPkg::CondCc: condEx = ~flags.c;
         armPkg::CondMi: condEx = flags.n;
         armPkg::CondPl: condEx = ~flags.n;
         armPkg::CondVs: condEx = flags.v;
         armPkg::CondVc: condEx = ~flags.v;
         armPkg::CondHi: condEx = flags.c & ~flags.z;
         armPkg::CondLs: condEx = ~flags.c | flags.z;
         armPkg::CondGe: condEx = (flags.n == flags.v);
         armPkg::CondLt: condEx = (flags.n != flags.v);
         armPkg::CondGt: condEx = ~flags.z & (flags.n == flags.v);
         armPkg::CondLe: condEx = flags.z | (flags.n != flags.v);
         armPkg::CondAl: condEx = 1'b1;
         // CondNv
         default:        condEx = 1'b0;
      endcase
   end

   // Stall and failed condition both squash the instruction
   assign execOk = condEx & PCReady;

   assign flagWrite = ctrl.flagW & {2{execOk}};
   assign regWrite  = ctrl.regW & execOk;
   assign pcBranch  = ctrl.branch & execOk;
   assign memWrite  = ctrl.memW & execOk;
   assign memStrobe = ctrl.memStrobe & execOk;

   // N/Z and C/V halves written separately
   always_ff @(posedge clk or posedge reset)
   begin
      if (reset)
      begin
         flags <= '0;
      end
      else
      begin
         if (flagWrite[1])
         begin
            flags.n <= flagsIn.n;
            flags.z <= flagsIn.z;
         end
         // Logic ops leave C/V alone
         if (flagWrite[0])
         begin
            flags.c <= flagsIn.c;
            flags.v <= flagsIn.v;
         end
      end
   end

endmodule

//--- rtl/datapath.sv
// PC resets to ResetPc and moves only when PCReady is high; B is the only PC redirect
module datapath #(
   parameter logic [31:0] ResetPc = 32'd0
) (
   input  logic             clk,
   input  logic             reset,
   input  armPkg::instrWord instr,
   input  armPkg::ctrlWord  ctrl,
   input  logic             regWrite,
   input  logic             pcBranch,
   input  logic             PCReady,
   output armPkg::aluFlags  flagsOut,
   output logic [31:0]      pc,
   output logic [31:0]      aluResult,
   output logic [31:0]      writeData,
   input  logic [31:0]      readData
);

   logic [31:0] pcPlus4;
   logic [31:0] pcPlus8;
   logic [31:0] pcNext;
   logic [3:0]  ra1;
   logic [3:0]  ra2;
   logic [31:0] srcA;
   logic [31:0] srcB;
   logic [31:0] extImm;
   logic [31:0] result;

   // Next PC, branch target comes from the ALU
   assign pcPlus4 = pc + armPkg::WordBytes;
   assign pcPlus8 = pc + armPkg::PcReadOffset;
   assign pcNext  = pcBranch ? aluResult : pcPlus4;

   // Stall holds the PC
   always_ff @(posedge clk or posedge reset)
   begin
      if (reset)
      begin
         pc <= ResetPc;
      end
      else if (PCReady)
      begin
         pc <= pcNext;
      end
   end

   // Branch reads R15, store reads rd on port 2
   assign ra1 = ctrl.regSrc[0] ? 4'd15 : instr.dpView.rn;
   assign ra2 = ctrl.regSrc[1] ? instr.dpView.rd : instr.dpView.src2[3:0];

   regFile regFile0 (
      .clk (clk),
      .we  (regWrite),
      .ra1 (ra1),
      .ra2 (ra2),
      .wa  (instr.dpView.rd),
      .wd  (result),
      .r15 (pcPlus8),
      .rd1 (srcA),
      .rd2 (writeData)
   );

   // Immediate extension
   always_comb
   begin
      case (ctrl.immSel)
         armPkg::ImmDp8:    extImm = {24'd0, instr.dpView.src2};
         armPkg::ImmMem12:  extImm = {20'd0, instr.memView.imm12};
         // Sign extend and scale to bytes
         armPkg::ImmBranch: extImm = {{6{instr.brView.imm24[23]}}, instr.brView.imm24, 2'b00};
         default:           extImm = 32'd0;
      endcase
   end

   assign srcB = ctrl.aluSrc ? extImm : writeData;

   alu alu0 (
      .a      (srcA),
      .b      (srcB),
      .ctl    (ctrl.aluCtl),
      .result (aluResult),
      .flags  (flagsOut)
   );

   // LDR result from memory, else ALU
   assign result = ctrl.memToReg ? readData : aluResult;

endmodule

//--- rtl/armCore.sv
// Single-cycle ARMv4 subset core with separate instruction and data ports and no BL
module armCore #(
   parameter logic [31:0] ResetPc = 32'd0
) (
   input  logic             clk,
   input  logic             reset,
   output logic [31:0]      PC,
   input  armPkg::instrWord Instr,
   output logic             MemWrite,
   output logic             MemStrobe,
   output logic [31:0]      ALUResult,
   output logic [31:0]      WriteData,
   input  logic [31:0]      ReadData,
   input  logic             PCReady
);

   armPkg::ctrlWord ctrl;
   armPkg::aluFlags flags;
   logic            regWrite;
   logic            pcBranch;

   armDecoder armDecoder0 (
      .instr (Instr),
      .ctrl  (ctrl)
   );

   // Gates all writes with condition and PCReady
   condUnit condUnit0 (
      .clk       (clk),
      .reset     (reset),
      .instr     (Instr),
      .ctrl      (ctrl),
      .flagsIn   (flags),
      .PCReady   (PCReady),
      .regWrite  (regWrite),
      .pcBranch  (pcBranch),
      .memWrite  (MemWrite),
      .memStrobe (MemStrobe)
   );

   datapath #(
      .ResetPc (ResetPc)
   ) datapath0 (
      .clk       (clk),
      .reset     (reset),
      .instr     (Instr),
      .ctrl      (ctrl),
      .regWrite  (regWrite),
      .pcBranch  (pcBranch),
      .PCReady   (PCReady),
      .flagsOut  (flags),
      .pc        (PC),
      .aluResult (ALUResult),
      .writeData (WriteData),
      .readData  (ReadData)
   );

endmodule

//--- test/armCore_chk.sv
// Port assertions for armCore, bound to every instance and disabled during reset
module armCoreChk (
   input logic        clk,
   input logic        reset,
   input logic        PCReady,
   input logic        MemWrite,
   input logic        MemStrobe,
   input logic [31:0] PC
);
   timeunit 1ns;
   timeprecision 1ps;

   // A store is always a strobed access
   writeHasStrobe: assert property (
      @(posedge clk) disable iff (reset) MemWrite |-> MemStrobe
   ) else $error("MemWrite high without MemStrobe");

   // No memory traffic while stalled
   stallNoMem: assert property (
      @(posedge clk) disable iff (reset) !PCReady |-> (!MemWrite && !MemStrobe)
   ) else $error("memory strobe during a stalled cycle");

   pcAligned: assert property (
      @(posedge clk) disable iff (reset) PC[1:0] == 2'b00
   ) else $error("PC not word aligned");

   // PC frozen across a stalled cycle
   stallHoldsPc: assert property (
      @(posedge clk) disable iff (reset) !PCReady |=> $stable(PC)
   ) else $error("PC moved during a stalled cycle");

endmodule

bind armCore armCoreChk armCoreChk0 (
   .clk       (clk),
   .reset     (reset),
   .PCReady   (PCReady),
   .MemWrite  (MemWrite),
   .MemStrobe (MemStrobe),
   .PC        (PC)
);

//--- test/armCoreTb.sv
// Self-checking testbench for armCore with ResetPc 0; LFSR stream with seed 80, no PC dependence
module armCoreTb;
   timeunit 1ns;
   timeprecision 1ps;

   // ORR r0, r0, #0 that never executes
   localparam logic [31:0] NopWord = {armPkg::CondNv, armPkg::OpData, 1'b1, armPkg::CmdOrr,
                                      1'b0, 4'd0, 4'd0, 4'd0, 8'd0};

   // Expected effect of the instruction in flight
   typedef struct packed {
      logic [31:0]     alu;
      logic [31:0]     wd;
      logic            memW;
      logic            strobe;
      logic            exec;
      logic            arith;
      armPkg::aluFlags flags;
   } prediction;

   logic             clk;
   logic             reset;
   logic [31:0]      PC;
   armPkg::instrWord Instr;
   logic             MemWrite;
   logic             MemStrobe;
   logic [31:0]      ALUResult;
   logic [31:0]      WriteData;
   logic [31:0]      ReadData;
   logic             PCReady;

   logic [15:0] lfsr;

   // Architectural model
   logic [31:0]     regs [15];
   logic [31:0]     mem [logic [31:0]];
   logic [31:0]     mPc;
   armPkg::aluFlags mFlags;
   prediction       pred;

   int errCount;
   int errAtStart;
   int passCount;
   int failCount;

   armCore #(
      .ResetPc (32'd0)
   ) dut0 (
      .clk       (clk),
      .reset     (reset),
      .PC        (PC),
      .Instr     (Instr),
      .MemWrite  (MemWrite),
      .MemStrobe (MemStrobe),
      .ALUResult (ALUResult),
      .WriteData (WriteData),
      .ReadData  (ReadData),
      .PCReady   (PCReady)
   );

   // 4 ns clock
   initial
   begin
      clk = 1'b0;
      forever
      begin
         #2 clk = ~clk;
      end
   end

   // Fibonacci LFSR, taps 16 14 13 11, one step per bit
   function automatic logic [31:0] randBits(input int n);
      logic [31:0] v;
      logic        fb;
      v = '0;
      for (int i = 0; i < n; i++)
      begin
         fb = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
         lfsr = {lfsr[14:0], fb};
         v = {v[30:0], fb};
      end
      return v;
   endfunction

   // r0..r14 only
   function automatic logic [3:0] randReg();
      return 4'(randBits(4) % 32'd15);
   endfunction

   function automatic logic [3:0] randCond();
      return 4'(randBits(4));
   endfunction

   function automatic logic [31:0] dpWord(input logic [3:0] cond, input logic sBit);
      logic [3:0] cmd;
      logic       immForm;
      logic [3:0] rn;
      logic [3:0] rd;
      logic [7:0] src2;
      case (2'(randBits(2)))
         2'd0:    cmd = armPkg::CmdAdd;
         2'd1:    cmd = armPkg::CmdSub;
         2'd2:    cmd = armPkg::CmdAnd;
         default: cmd = armPkg::CmdOrr;
      endcase
      immForm = 1'(randBits(1));
      rn = randReg();
      rd = randReg();
      // Register form keeps rm in the low nibble
      src2 = immForm ? 8'(randBits(8)) : {4'd0, randReg()};
      return {cond, armPkg::OpData, immForm, cmd, sBit, rn, rd, 4'd0, src2};
   endfunction

   // Immediate offset, pre-indexed, add, word, no writeback
   function automatic logic [31:0] memWord(input logic [3:0] cond, input logic lBit,
                                           input logic [3:0] rd);
      logic [3:0]  rn;
      logic [11:0] imm12;
      rn = randReg();
      imm12 = 12'(randBits(12));
      return {cond, armPkg::OpMem, 5'b01100, lBit, rn, rd, imm12};
   endfunction

   function automatic logic [31:0] brWord(input logic [3:0] cond);
      return {cond, armPkg::OpBranch, 2'b10, 24'(randBits(24))};
   endfunction

   // R15 reads as PC+8
   function automatic logic [31:0] regRead(input logic [3:0] r);
      if (r == 4'd15)
         return mPc + 32'd8;
      return regs[r];
   endfunction

   function automatic logic [31:0] memRead(input logic [31:0] addr);
      if (mem.exists(addr))
         return mem[addr];
      // Untouched words, pattern of the full address
      return {addr[15:0], addr[31:16]} ^ 32'hC3A5_5A3C;
   endfunction

   function automatic logic condHolds(input logic [3:0] cond);
      case (cond)
         4'd0:    return mFlags.z;
         4'd1:    return !mFlags.z;
         4'd2:    return mFlags.c;
         4'd3:    return !mFlags.c;
         4'd4:    return mFlags.n;
         4'd5:    return !mFlags.n;
         4'd6:    return mFlags.v;
         4'd7:    return !mFlags.v;
         4'd8:    return mFlags.c && !mFlags.z;
         4'd9:    return !mFlags.c || mFlags.z;
         4'd10:   return mFlags.n == mFlags.v;
         4'd11:   return mFlags.n != mFlags.v;
         4'd12:   return !mFlags.z && (mFlags.n == mFlags.v);
         4'd13:   return mFlags.z || (mFlags.n != mFlags.v);
         4'd14:   return 1'b1;
         // Never
         default: return 1'b0;
      endcase
   endfunction

   task automatic predict(input logic [31:0] w, input logic ready);
      logic [31:0] a;
      logic [31:0] b;
      logic [32:0] sum;
      logic [3:0]  cmd;
      // Memory and branch add
      cmd = (w[27:26] == armPkg::OpData) ? w[24:21] : armPkg::CmdAdd;
      a = regRead(w[19:16]);
      if (w[27:26] == armPkg::OpBranch)
      begin
         a = mPc + 32'd8;
         b = {{6{w[23]}}, w[23:0], 2'b00};
      end
      else if (w[27:26] == armPkg::OpMem)
         b = {20'd0, w[11:0]};
      else
         b = w[25] ? {24'd0, w[7:0]} : regRead(w[3:0]);
      sum = {1'b0, a} + {1'b0, b};
      pred.arith = 1'b1;
      pred.flags.v = (a[31] == b[31]) && (sum[31] != a[31]);
      pred.alu = sum[31:0];
      case (cmd)
         armPkg::CmdSub:
         begin
            sum = {1'b0, a} + {1'b0, ~b} + 33'd1;
            pred.flags.v = (a[31] != b[31]) && (sum[31] != a[31]);
            pred.alu = sum[31:0];
         end
         armPkg::CmdAnd:
         begin
            pred.alu = a & b;
            pred.arith = 1'b0;
         end
         armPkg::CmdOrr:
         begin
            pred.alu = a | b;
            pred.arith = 1'b0;
         end
         default:
         begin
         end
      endcase
      pred.flags.n = pred.alu[31];
      pred.flags.z = (pred.alu == 32'd0);
      pred.flags.c = sum[32];
      pred.exec = ready && condHolds(w[31:28]);
      pred.wd = regRead(w[15:12]);
      pred.strobe = pred.exec && (w[27:26] == armPkg::OpMem);
      pred.memW = pred.strobe && !w[20];
   endtask

   task automatic commit(input logic [31:0] w, input logic ready, input logic [31:0] rdData);
      // Stalled cycle leaves all state alone
      if (!ready)
         return;
      mPc = mPc + 32'd4;
      if (!pred.exec)
         return;
      case (w[27:26])
         armPkg::OpData:
         begin
            regs[w[15:12]] = pred.alu;
            if (w[20])
            begin
               mFlags.n = pred.flags.n;
               mFlags.z = pred.flags.z;
               // Logic ops keep C and V
               if (pred.arith)
               begin
                  mFlags.c = pred.flags.c;
                  mFlags.v = pred.flags.v;
               end
            end
         end
         armPkg::OpMem:
         begin
            if (w[20])
               regs[w[15:12]] = rdData;
            else
               mem[pred.alu] = pred.wd;
         end
         default:
            mPc = pred.alu;
      endcase
   endtask

   task automatic reportValue(input string name, input logic [31:0] expVal,
                              input logic [31:0] actVal);
      $display("ERR %0t %s expected %h actual %h", $time, name, expVal, actVal);
      errCount++;
   endtask

   // One instruction per cycle, outputs sampled mid-cycle
   task automatic issue(input logic [31:0] w, input logic ready);
      logic [31:0] rdData;
      predict(w, ready);
      rdData = memRead(pred.alu);
      @(posedge clk);
      Instr <= w;
      PCReady <= ready;
      ReadData <= rdData;
      @(negedge clk);
      if (PC !== mPc)
         reportValue("PC", mPc, PC);
      if (ALUResult !== pred.alu)
         reportValue("ALUResult", pred.alu, ALUResult);
      if (MemWrite !== pred.memW)
         reportValue("MemWrite", {31'd0, pred.memW}, {31'd0, MemWrite});
      if (MemStrobe !== pred.strobe)
         reportValue("MemStrobe", {31'd0, pred.strobe}, {31'd0, MemStrobe});
      if ((w[27:26] == armPkg::OpMem) && !w[20] && (WriteData !== pred.wd))
         reportValue("WriteData", pred.wd, WriteData);
      commit(w, ready, rdData);
   endtask

   task automatic waitReset();
      int waited;
      waited = 0;
      @(negedge clk);
      while ((PC !== mPc) && (waited < 10))
      begin
         @(negedge clk);
         waited++;
      end
      if (PC !== mPc)
      begin
         $display("Timeout: PC did not reach its reset value within 10 cycles");
         $display("Testbench failed");
         $finish;
      end
   endtask

   task automatic endTest(input string name);
      if (errCount == errAtStart)
      begin
         $display("%s: ok", name);
         passCount++;
      end
      else
      begin
         $display("%s: %0d errors", name, errCount - errAtStart);
         failCount++;
      end
      errAtStart = errCount;
   endtask

   initial
   begin
      logic [3:0]  rd;
      logic [31:0] w;
      logic        ready;
      lfsr = 16'd80;
      errCount = 0;
      errAtStart = 0;
      passCount = 0;
      failCount = 0;
      mPc = 32'd0;
      mFlags = '0;
      // Stalled never-executed ORR through reset
      reset <= 1'b1;
      Instr <= NopWord;
      PCReady <= 1'b0;
      ReadData <= 32'd0;
      repeat (4) @(posedge clk);
      reset <= 1'b0;
      waitReset();

      // Clear via R15 then load a small immediate
      for (int i = 0; i < 15; i++)
      begin
         issue({armPkg::CondAl, armPkg::OpData, 1'b1, armPkg::CmdAnd, 1'b0, 4'd15,
                4'(i), 4'd0, 8'd0}, 1'b1);
         issue({armPkg::CondAl, armPkg::OpData, 1'b1, armPkg::CmdOrr, 1'b0, 4'(i),
                4'(i), 4'd0, 8'(randBits(8))}, 1'b1);
      end
      for (int i = 0; i < 300; i++)
         issue(dpWord(armPkg::CondAl, 1'b0), 1'b1);
      endTest("register init and data processing");

      // Stores with random cond make skipped instructions visible
      for (int i = 0; i < 300; i++)
      begin
         if (randBits(2) == 0)
            issue(memWord(randCond(), 1'b0, randReg()), 1'b1);
         else
            issue(dpWord(randCond(), 1'(randBits(1))), 1'b1);
      end
      endTest("flags and conditions");

      // Loaded value shows on the next store of the same register
      for (int i = 0; i < 150; i++)
      begin
         rd = randReg();
         if (randBits(1))
            issue(memWord(armPkg::CondAl, 1'b1, rd), 1'b1);
         issue(memWord(armPkg::CondAl, 1'b0, rd), 1'b1);
         issue(dpWord(randCond(), 1'(randBits(1))), 1'b1);
      end
      endTest("memory");

      for (int i = 0; i < 150; i++)
      begin
         if (randBits(1))
            issue(brWord(randCond()), 1'b1);
         else
            issue(dpWord(randCond(), 1'(randBits(1))), 1'b1);
      end
      endTest("branch");

      // PCReady low about one cycle in eight
      for (int i = 0; i < 300; i++)
      begin
         ready = (randBits(3) != 0);
         case (2'(randBits(2)))
            2'd0:    w = dpWord(randCond(), 1'(randBits(1)));
            2'd1:    w = dpWord(armPkg::CondAl, 1'b0);
            2'd2:    w = memWord(randCond(), 1'(randBits(1)), randReg());
            default: w = brWord(randCond());
         endcase
         issue(w, ready);
      end
      // One more cycle to check the final PC
      issue(NopWord, 1'b1);
      endTest("stall");

      $display("%0d tests passed, %0d tests failed", passCount, failCount);
      if (failCount == 0)
         $display("Testbench passed");
      else
         $display("Testbench failed");
      $finish;
   end

endmodule

//--- filelist.f
rtl/armPkg.sv
rtl/alu.sv
rtl/regFile.sv
rtl/armDecoder.sv
rtl/condUnit.sv
rtl/datapath.sv
rtl/armCore.sv
test/armCore_chk.sv
test/armCoreTb.sv

//--- Makefile
# Verilator build and run for the armCore testbench
VERILATOR ?= verilator
TOP       ?= armCoreTb
FILELIST  ?= filelist.f
OBJDIR    ?= obj_dir
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps
PASS_TEXT ?= Testbench passed

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)
	@out="$$(./$(OBJDIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_TEXT)"

clean:
	rm -rf $(OBJDIR)
